// ==== compile.f ====
+incdir+verilog
+incdir+sim
verilog/decode_pkg.sv
verilog/decode_input_reg.sv
verilog/instr_field_decoder.sv
verilog/instr_ctrl_decoder.sv
verilog/decode_stage.sv
sim/decode_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decode_pkg.sv
      - verilog/decode_input_reg.sv
      - verilog/instr_field_decoder.sv
      - verilog/instr_ctrl_decoder.sv
      - verilog/decode_stage.sv
  - target: simulation
    include_dirs:
      - verilog
      - sim
    files:
      - sim/decode_tb.sv

// ==== sim/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// One decode test: the word and PC to drive, plus the expected execute bundle
// Enum fields as raw codes, ordered as in the package
typedef struct packed {
    logic [8*12-1:0]      name;
    logic [`DEC_XLEN-1:0] instr;
    logic [`DEC_XLEN-1:0] pc;
    logic [3:0]           alu_op;
    logic [1:0]           op1_src;
    logic [1:0]           op2_src;
    logic [`DEC_XLEN-1:0] imm;
    logic                 rd_we;
    logic [1:0]           mem_op;
    logic [1:0]           mem_size;
    logic                 mem_signed;
    logic [1:0]           branch;
    logic [2:0]           cmp_op;
    logic                 illegal;
} vec_s;

localparam int NUM_VECS = 26;

// Columns: name, instr, pc, alu_op, op1, op2, imm, rd_we, mem_op, size, signed,
// branch, cmp, illegal
localparam vec_s VECS [NUM_VECS] = '{
    '{"add",      'h002081B3, 'h00001000, 0, 0, 0, `DEC_IMM_BAD, 1, 0, 0, 0, 0, 0, 0},
    '{"sub",      'h407302B3, 'h00001004, 1, 0, 0, `DEC_IMM_BAD, 1, 0, 0, 0, 0, 0, 0},
    '{"sra",      'h40A4D433, 'h00001008, 7, 0, 0, `DEC_IMM_BAD, 1, 0, 0, 0, 0, 0, 0},
    '{"sltu",     'h003130B3, 'h0000100C, 4, 0, 0, `DEC_IMM_BAD, 1, 0, 0, 0, 0, 0, 0},
    '{"addi_m1",  'hFFF00093, 'h00001010, 0, 0, 1, 'hFFFFFFFF, 1, 0, 0, 0, 0, 0, 0},
    '{"srai",     'h4032D213, 'h00001014, 7, 0, 1, 'h00000403, 1, 0, 0, 0, 0, 0, 0},
    '{"xori",     'h7FF1C113, 'h00001018, 5, 0, 1, 'h000007FF, 1, 0, 0, 0, 0, 0, 0},
    // Bit 30 set but OP_IMM has no SUB
    '{"addi_neg", 'hC0008093, 'h0000101C, 0, 0, 1, 'hFFFFFC00, 1, 0, 0, 0, 0, 0, 0},
    '{"lw",       'h00812283, 'h00002000, 0, 0, 1, 'h00000008, 1, 1, 2, 1, 0, 0, 0},
    '{"lbu",      'hFFF0C303, 'h00002004, 0, 0, 1, 'hFFFFFFFF, 1, 1, 0, 0, 0, 0, 0},
    '{"lh_x0",    'h00209003, 'h00002008, 0, 0, 1, 'h00000002, 0, 1, 1, 1, 0, 0, 0},
    '{"sw",       'hFE712E23, 'h0000200C, 0, 0, 1, 'hFFFFFFFC, 0, 2, 2, 0, 0, 0, 0},
    '{"sb",       'h003202A3, 'h00002010, 0, 0, 1, 'h00000005, 0, 2, 0, 0, 0, 0, 0},
    '{"beq_back", 'hFE208CE3, 'h00003000, 0, 0, 0, 'hFFFFFFF8, 0, 0, 0, 0, 1, 0, 0},
    '{"bgeu",     'h0062F863, 'h00003004, 0, 0, 0, 'h00000010, 0, 0, 0, 0, 1, 7, 0},
    // Offset bit 11 comes from instr[7]
    '{"blt_2k",   'h0020C0E3, 'h00003008, 0, 0, 0, 'h00000800, 0, 0, 0, 0, 1, 4, 0},
    '{"jal",      'h001000EF, 'h00004000, 0, 1, 2, 'h00000800, 1, 0, 0, 0, 3, 0, 0},
    '{"jal_x0",   'hFFDFF06F, 'h00004004, 0, 1, 2, 'hFFFFFFFC, 0, 0, 0, 0, 3, 0, 0},
    '{"jalr",     'h004280E7, 'h00004008, 0, 1, 2, 'h00000004, 1, 0, 0, 0, 2, 0, 0},
    '{"lui",      'h12345537, 'h00005000, 0, 2, 1, 'h12345000, 1, 0, 0, 0, 0, 0, 0},
    '{"auipc",    'hFFFFF197, 'h00005004, 0, 1, 1, 'hFFFFF000, 1, 0, 0, 0, 0, 0, 0},
    '{"ecall",    'h00000073, 'h00006000, 0, 0, 0, `DEC_IMM_BAD, 0, 0, 0, 0, 0, 0, 1},
    '{"fence",    'h0FF0000F, 'h00006004, 0, 0, 0, `DEC_IMM_BAD, 0, 0, 0, 0, 0, 0, 1},
    '{"amoadd",   'h0020A2AF, 'h00006008, 0, 0, 0, `DEC_IMM_BAD, 0, 0, 0, 0, 0, 0, 1},
    // addi encoding in quadrant 01, immediate still decoded
    '{"rvc_word", 'hFFF00091, 'h0000600C, 0, 0, 0, 'hFFFFFFFF, 0, 0, 0, 0, 0, 0, 1},
    '{"bad_op",   'h0000007F, 'h00006010, 0, 0, 0, `DEC_IMM_BAD, 0, 0, 0, 0, 0, 0, 1}
};

`endif

// ==== sim/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_tb;

    localparam int NUM_RAND = 16;
    localparam int STALL_IDX = 8;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           d_stall;
    logic                           d_flush;
    logic                           f2_to_d_valid;
    decode_pkg::fetch_to_decode_s   f2_to_d;
    logic [`DEC_XLEN-1:0]           rf_rs1_val;
    logic [`DEC_XLEN-1:0]           rf_rs2_val;
    logic [`DEC_REG_IDX_W-1:0]      rf_rs1_idx;
    logic [`DEC_REG_IDX_W-1:0]      rf_rs2_idx;
    logic                           d_to_e_valid;
    decode_pkg::decode_to_execute_s d_to_e;
    int                             pass_count;
    int                             fail_count;
    logic [31:0]                    lcg_state;

    `include "decode_vectors.svh"

    // Reset, two cycles per decode test, flow tests
    localparam int RUN_CYCLES = 4 + 2 * (NUM_VECS + NUM_RAND) + 16;

    // ALU op per funct3 before the funct7[5] variants
    localparam logic [3:0] ALU_BASE [8] = '{4'd0, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd8, 4'd9};

    always #5 clk = ~clk;

    // Register file answers index * 0x01010101 in the same cycle
    assign rf_rs1_val = {27'b0, rf_rs1_idx} * 32'h01010101;
    assign rf_rs2_val = {27'b0, rf_rs2_idx} * 32'h01010101;

    decode_stage dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_stall       (d_stall),
        .d_flush       (d_flush),
        .f2_to_d_valid (f2_to_d_valid),
        .f2_to_d       (f2_to_d),
        .rf_rs1_val    (rf_rs1_val),
        .rf_rs2_val    (rf_rs2_val),
        .rf_rs1_idx    (rf_rs1_idx),
        .rf_rs2_idx    (rf_rs2_idx),
        .d_to_e_valid  (d_to_e_valid),
        .d_to_e        (d_to_e)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic expect_eq(input logic [8*12-1:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act,
                             inout int errs);
        if (act !== exp) begin
            $display("FAIL %0s %0s: expected %h, actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic finish_test(input logic [8*12-1:0] name, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("PASS %0s", name);
        end else begin
            fail_count++;
            $display("test %0s failed with %0d wrong fields", name, errs);
        end
    endtask

    // Register slots are fixed, so indexes and read values follow the raw word
    task automatic check_decode(input vec_s v, inout int errs);
        expect_eq(v.name, "valid", 1, d_to_e_valid, errs);
        expect_eq(v.name, "pc", v.pc, d_to_e.pc, errs);
        expect_eq(v.name, "rd_idx", v.instr[11:7], d_to_e.rd_idx, errs);
        expect_eq(v.name, "rs1_idx", v.instr[19:15], d_to_e.rs1_idx, errs);
        expect_eq(v.name, "rs2_idx", v.instr[24:20], d_to_e.rs2_idx, errs);
        expect_eq(v.name, "rf_rs1_idx", v.instr[19:15], rf_rs1_idx, errs);
        expect_eq(v.name, "rf_rs2_idx", v.instr[24:20], rf_rs2_idx, errs);
        expect_eq(v.name, "rs1_val", v.instr[19:15] * 32'h01010101, d_to_e.rs1_val, errs);
        expect_eq(v.name, "rs2_val", v.instr[24:20] * 32'h01010101, d_to_e.rs2_val, errs);
        expect_eq(v.name, "immediate", v.imm, d_to_e.immediate, errs);
        expect_eq(v.name, "alu_op", v.alu_op, d_to_e.ctrl.alu_op, errs);
        expect_eq(v.name, "op1_src", v.op1_src, d_to_e.ctrl.alu_op1_src, errs);
        expect_eq(v.name, "op2_src", v.op2_src, d_to_e.ctrl.alu_op2_src, errs);
        expect_eq(v.name, "rd_we", v.rd_we, d_to_e.ctrl.rd_we, errs);
        // Only loads write back from memory
        expect_eq(v.name, "rd_src", v.mem_op == 2'd1, d_to_e.ctrl.rd_src, errs);
        expect_eq(v.name, "mem_op", v.mem_op, d_to_e.ctrl.mem_op, errs);
        expect_eq(v.name, "mem_size", v.mem_size, d_to_e.ctrl.mem_size, errs);
        expect_eq(v.name, "mem_signed", v.mem_signed, d_to_e.ctrl.mem_signed, errs);
        expect_eq(v.name, "branch", v.branch, d_to_e.ctrl.branch, errs);
        expect_eq(v.name, "cmp_op", v.cmp_op, d_to_e.ctrl.cmp_op, errs);
        expect_eq(v.name, "illegal", v.illegal, d_to_e.ctrl.illegal, errs);
    endtask

    // Valid for one cycle, decode checked in the cycle after capture
    task automatic run_vector(input vec_s v);
        int errs;
        @(posedge clk);
        f2_to_d_valid <= 1'b1;
        f2_to_d.pc <= v.pc;
        f2_to_d.instr <= v.instr;
        @(posedge clk);
        f2_to_d_valid <= 1'b0;
        @(negedge clk);
        errs = 0;
        check_decode(v, errs);
        finish_test(v.name, errs);
    endtask

    // Random OP or OP_IMM word with its expected decode
    task automatic build_random(output vec_s v);
        logic [31:0] r;
        logic        is_op;
        logic        alt;
        logic [2:0]  f3;
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
        is_op = r[31];
        f3 = r[30:28];
        alt = r[27];
        v = '0;
        v.name = is_op ? "rand_op" : "rand_imm";
        v.instr = {1'b0, alt, 5'b0, r[26:22], r[21:17], f3, r[16:12],
                   is_op ? 7'h33 : 7'h13};
        lcg_state = lcg_next(lcg_state);
        v.pc = {lcg_state[31:2], 2'b00};
        v.alu_op = ALU_BASE[f3];
        // SUB only for register-register
        if (f3 == 3'd0 && alt && is_op) begin
            v.alu_op = 4'd1;
        end
        if (f3 == 3'd5 && alt) begin
            v.alu_op = 4'd7;
        end
        v.op2_src = is_op ? 2'd0 : 2'd1;
        v.imm = is_op ? `DEC_IMM_BAD : {{20{v.instr[31]}}, v.instr[31:20]};
        v.rd_we = (v.instr[11:7] != 5'd0);
    endtask

    task automatic flush_test();
        int errs;
        errs = 0;
        @(posedge clk);
        f2_to_d_valid <= 1'b1;
        f2_to_d.pc <= VECS[0].pc;
        f2_to_d.instr <= VECS[0].instr;
        @(posedge clk);
        f2_to_d_valid <= 1'b0;
        d_flush <= 1'b1;
        @(negedge clk);
        expect_eq("flush", "valid in flush", 0, d_to_e_valid, errs);
        @(posedge clk);
        d_flush <= 1'b0;
        // Flushed entry must not come back
        @(negedge clk);
        expect_eq("flush", "valid after", 0, d_to_e_valid, errs);
        finish_test("flush", errs);
    endtask

    task automatic stall_test();
        vec_s v;
        int   errs;
        v = VECS[STALL_IDX];
        errs = 0;
        @(posedge clk);
        f2_to_d_valid <= 1'b1;
        f2_to_d.pc <= v.pc;
        f2_to_d.instr <= v.instr;
        @(posedge clk);
        f2_to_d_valid <= 1'b0;
        d_stall <= 1'b1;
        // Fresh fetch data that the held word must ignore
        f2_to_d.pc <= 32'h0000BAD0;
        f2_to_d.instr <= 32'h00000013;
        repeat (2) begin
            @(negedge clk);
            expect_eq("stall", "valid in stall", 0, d_to_e_valid, errs);
            expect_eq("stall", "held pc", v.pc, d_to_e.pc, errs);
            @(posedge clk);
        end
        d_stall <= 1'b0;
        // Held decode comes back with valid
        @(negedge clk);
        check_decode(v, errs);
        finish_test("stall", errs);
    endtask

    initial begin
        vec_s v;
        int   errs;
        rst_n = 1'b0;
        d_stall = 1'b0;
        d_flush = 1'b0;
        // Offered during reset, the register must drop it
        f2_to_d_valid = 1'b1;
        f2_to_d = '0;
        pass_count = 0;
        fail_count = 0;
        lcg_state = 32'h131c;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        f2_to_d_valid <= 1'b0;
        @(negedge clk);
        errs = 0;
        expect_eq("reset", "valid", 0, d_to_e_valid, errs);
        finish_test("reset", errs);
        for (int i = 0; i < NUM_VECS; i++) begin
            run_vector(VECS[i]);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            build_random(v);
            run_vector(v);
        end
        flush_test();
        stall_test();
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, four times the expected run length
    initial begin
        #(RUN_CYCLES * 10 * 4);
        $display("Timeout: decode tests did not finish within %0d cycles", RUN_CYCLES * 4);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           d_stall,
    input  logic                           d_flush,
    input  logic                           f2_to_d_valid,
    input  decode_pkg::fetch_to_decode_s   f2_to_d,
    input  logic [`DEC_XLEN-1:0]           rf_rs1_val,
    input  logic [`DEC_XLEN-1:0]           rf_rs2_val,
    output logic [`DEC_REG_IDX_W-1:0]      rf_rs1_idx,
    output logic [`DEC_REG_IDX_W-1:0]      rf_rs2_idx,
    output logic                           d_to_e_valid,
    output decode_pkg::decode_to_execute_s d_to_e
);

    logic                         held_valid;
    decode_pkg::fetch_to_decode_s held;
    decode_pkg::instr_fields_s    fields;
    decode_pkg::decode_ctrl_s     ctrl;

    // One-cycle boundary from fetch
    decode_input_reg u_input_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .d_stall     (d_stall),
        .in_valid    (f2_to_d_valid),
        .in_bundle   (f2_to_d),
        .held_valid  (held_valid),
        .held_bundle (held)
    );

    // Both decoders are pure logic on the held word
    instr_field_decoder u_field_dec (
        .instr  (held.instr),
        .fields (fields)
    );

    instr_ctrl_decoder u_ctrl_dec (
        .instr  (held.instr),
        .fields (fields),
        .ctrl   (ctrl)
    );

    // Register file read, values return in the same cycle
    assign rf_rs1_idx = fields.rs1;
    assign rf_rs2_idx = fields.rs2;

    always_comb begin
        d_to_e.pc        = held.pc;
        d_to_e.rd_idx    = fields.rd;
        d_to_e.rs1_idx   = fields.rs1;
        d_to_e.rs2_idx   = fields.rs2;
        d_to_e.rs1_val   = rf_rs1_val;
        d_to_e.rs2_val   = rf_rs2_val;
        d_to_e.immediate = fields.imm;
        d_to_e.ctrl      = ctrl;
    end

    // Bundle stays visible, only the valid is gated
    assign d_to_e_valid = held_valid && !d_flush && !d_stall;

    // Hazard unit contract
    assert property (@(posedge clk) disable iff (!rst_n)
        !(d_flush && d_stall))
        else $error("flush and stall high together");

    // Held word plus register file data must be clean when handed on
    assert property (@(posedge clk) disable iff (!rst_n)
        d_to_e_valid |-> !$isunknown(d_to_e))
        else $error("valid decode output carries unknown bits");

endmodule

// ==== verilog/instr_ctrl_decoder.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module instr_ctrl_decoder (
    input  logic [`DEC_XLEN-1:0]      instr,
    input  decode_pkg::instr_fields_s fields,
    output decode_pkg::decode_ctrl_s  ctrl
);

    decode_pkg::opcode_e opcode;
    logic                rd_nz;
    logic                quadrant_ok;

    // ALU op shared by OP and OP_IMM
    // alt is funct7[5]; SUB only exists for register-register
    function automatic decode_pkg::alu_op_e alu_op_sel(
        input logic [`DEC_FUNCT3_W-1:0] funct3,
        input logic                     alt,
        input logic                     sub_ok
    );
        decode_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = (alt && sub_ok) ? decode_pkg::ALU_OP_SUB : decode_pkg::ALU_OP_ADD;
            3'b001:  op = decode_pkg::ALU_OP_SLL;
            3'b010:  op = decode_pkg::ALU_OP_SLT;
            3'b011:  op = decode_pkg::ALU_OP_SLTU;
            3'b100:  op = decode_pkg::ALU_OP_XOR;
            3'b101:  op = alt ? decode_pkg::ALU_OP_SRA : decode_pkg::ALU_OP_SRL;
            3'b110:  op = decode_pkg::ALU_OP_OR;
            default: op = decode_pkg::ALU_OP_AND;
        endcase
        return op;
    endfunction

    assign opcode = decode_pkg::opcode_e'(instr[`DEC_OPCODE_W+1:2]);

    // Writes to x0 are dropped here, keeps forwarding simple
    assign rd_nz = (fields.rd != '0);

    // Only 32-bit encodings, no compressed quadrants
    assign quadrant_ok = (instr[1:0] == 2'b11);

    always_comb begin
        // All-zero default: no write, no memory access, no branch
        ctrl = '0;
        unique case (opcode)
            decode_pkg::OPCODE_OP: begin
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_RS1;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_RS2;
                ctrl.alu_op      = alu_op_sel(fields.funct3, fields.funct7[5], 1'b1);
            end
            decode_pkg::OPCODE_OP_IMM: begin
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_RS1;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_IMM;
                ctrl.alu_op      = alu_op_sel(fields.funct3, fields.funct7[5], 1'b0);
            end
            decode_pkg::OPCODE_LOAD: begin
                // Address is rs1 plus offset
                ctrl.rd_src      = decode_pkg::RD_SRC_MEM;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_RS1;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_IMM;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
                ctrl.mem_op      = decode_pkg::MEM_OP_LOAD;
                // LBU and LHU set funct3[2]
                ctrl.mem_signed  = !fields.funct3[2];
                ctrl.mem_size    = decode_pkg::mem_size_e'(fields.funct3[1:0]);
            end
            decode_pkg::OPCODE_STORE: begin
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_RS1;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_IMM;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
                ctrl.mem_op      = decode_pkg::MEM_OP_STORE;
                ctrl.mem_size    = decode_pkg::mem_size_e'(fields.funct3[1:0]);
            end
            decode_pkg::OPCODE_BRANCH: begin
                // Compare of rs1 and rs2 happens in execute
                ctrl.branch = decode_pkg::BRANCH_COND;
                ctrl.cmp_op = decode_pkg::cmp_op_e'(fields.funct3);
            end
            decode_pkg::OPCODE_JAL: begin
                // Link value is pc + 4
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_FOUR;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
                ctrl.branch      = decode_pkg::BRANCH_JAL;
            end
            decode_pkg::OPCODE_JALR: begin
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_FOUR;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
                ctrl.branch      = decode_pkg::BRANCH_JALR;
            end
            decode_pkg::OPCODE_LUI: begin
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_ZERO;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_IMM;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
            end
            decode_pkg::OPCODE_AUIPC: begin
                ctrl.rd_src      = decode_pkg::RD_SRC_ALU;
                ctrl.rd_we       = rd_nz;
                ctrl.alu_op1_src = decode_pkg::ALU_OP1_SRC_PC;
                ctrl.alu_op2_src = decode_pkg::ALU_OP2_SRC_IMM;
                ctrl.alu_op      = decode_pkg::ALU_OP_ADD;
            end
            // Not supported by this core
            decode_pkg::OPCODE_SYSTEM,
            decode_pkg::OPCODE_AMO,
            decode_pkg::OPCODE_MISC_MEM: ctrl.illegal = 1'b1;
            default:                     ctrl.illegal = 1'b1;
        endcase

        // Not a 32-bit word, strip every side effect
        if (!quadrant_ok) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end

        // Destination read from the raw word, apart from the field bundle
        assert (!ctrl.rd_we || (instr[11:7] != '0))
            else $error("rd_we set with x0 destination");
    end

endmodule

// ==== verilog/instr_field_decoder.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module instr_field_decoder (
    input  logic [`DEC_XLEN-1:0]      instr,
    output decode_pkg::instr_fields_s fields
);

    decode_pkg::opcode_e       opcode;
    decode_pkg::instr_format_e fmt;
    logic                      sign;
    logic [`DEC_XLEN-1:0]      imm_i;
    logic [`DEC_XLEN-1:0]      imm_s;
    logic [`DEC_XLEN-1:0]      imm_b;
    logic [`DEC_XLEN-1:0]      imm_u;
    logic [`DEC_XLEN-1:0]      imm_j;

    assign opcode = decode_pkg::opcode_e'(instr[`DEC_OPCODE_W+1:2]);

    // Every immediate takes its sign from bit 31
    assign sign = instr[`DEC_XLEN-1];

    // Format only for the kept opcodes
    // Dropped ones fall to BAD with the unknown encodings
    always_comb begin
        unique case (opcode)
            decode_pkg::OPCODE_OP:     fmt = decode_pkg::FMT_R;
            decode_pkg::OPCODE_LOAD,
            decode_pkg::OPCODE_OP_IMM,
            decode_pkg::OPCODE_JALR:   fmt = decode_pkg::FMT_I;
            decode_pkg::OPCODE_STORE:  fmt = decode_pkg::FMT_S;
            decode_pkg::OPCODE_BRANCH: fmt = decode_pkg::FMT_B;
            decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC:  fmt = decode_pkg::FMT_U;
            decode_pkg::OPCODE_JAL:    fmt = decode_pkg::FMT_J;
            default:                   fmt = decode_pkg::FMT_BAD;
        endcase
    end

    // I: 12 bits straight from the top
    assign imm_i = {{(`DEC_XLEN-12){sign}}, instr[31:20]};

    // S: upper seven bits plus the rd slot
    assign imm_s = {{(`DEC_XLEN-12){sign}}, instr[31:25], instr[11:7]};

    // B: halfword offset, bit 11 sits in instr[7]
    assign imm_b = {{(`DEC_XLEN-13){sign}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    // U: upper 20 bits, low 12 cleared
    assign imm_u = {instr[31:12], 12'h000};

    // J: halfword offset, scrambled 20-bit field
    assign imm_j = {{(`DEC_XLEN-21){sign}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Fixed slots, valid or not for the format
        fields.rd     = instr[11:7];
        fields.rs1    = instr[19:15];
        fields.rs2    = instr[24:20];
        fields.funct3 = instr[14:12];
        fields.funct7 = instr[31:25];
        fields.format = fmt;

        unique case (fmt)
            decode_pkg::FMT_I: fields.imm = imm_i;
            decode_pkg::FMT_S: fields.imm = imm_s;
            decode_pkg::FMT_B: fields.imm = imm_b;
            decode_pkg::FMT_U: fields.imm = imm_u;
            decode_pkg::FMT_J: fields.imm = imm_j;
            // R and BAD carry no immediate
            default:           fields.imm = `DEC_IMM_BAD;
        endcase
    end

endmodule

// ==== verilog/decode_input_reg.sv ====
`timescale 1ns/1ps

module decode_input_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         d_stall,
    input  logic                         in_valid,
    input  decode_pkg::fetch_to_decode_s in_bundle,
    output logic                         held_valid,
    output decode_pkg::fetch_to_decode_s held_bundle
);

    // Valid is the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (!d_stall) begin
            held_valid <= in_valid;
        end
    end

    // PC and instruction word, frozen while stalled
    always_ff @(posedge clk) begin
        if (!d_stall) begin
            held_bundle <= in_bundle;
        end
    end

    // Hazard unit never offers a new instruction into a stalled stage
    assert property (@(posedge clk) disable iff (!rst_n)
        d_stall |-> !in_valid)
        else $error("decode input valid high during stall");

    // Stalled edge leaves the held PC and word untouched for the next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        d_stall |=> $stable(held_bundle))
        else $error("decode input register changed across a stall");

endmodule

// ==== verilog/decode_pkg.sv ====
`include "decode_cfg.svh"

package decode_pkg;

    // Major opcodes, instr[6:2]
    // SYSTEM, AMO and MISC_MEM are named only so they can be rejected
    typedef enum logic [`DEC_OPCODE_W-1:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_BAD = 3'b000,
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } instr_format_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD = 4'd0,
        ALU_OP_SUB,
        ALU_OP_SLL,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_XOR,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_OR,
        ALU_OP_AND
    } alu_op_e;

    // Zero encodings are the plain register sources
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1 = 2'd0,
        ALU_OP1_SRC_PC,
        ALU_OP1_SRC_ZERO
    } alu_op1_src_e;

    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS2 = 2'd0,
        ALU_OP2_SRC_IMM,
        ALU_OP2_SRC_FOUR
    } alu_op2_src_e;

    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_MEM = 1'b1
    } rd_src_e;

    typedef enum logic [1:0] {
        MEM_OP_NONE = 2'd0,
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    // Same values as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        BRANCH_NONE = 2'd0,
        BRANCH_COND,
        BRANCH_JALR,
        BRANCH_JAL
    } branch_e;

    // Branch compares, encoded as their funct3
    typedef enum logic [`DEC_FUNCT3_W-1:0] {
        CMP_OP_EQ  = 3'b000,
        CMP_OP_NE  = 3'b001,
        CMP_OP_LT  = 3'b100,
        CMP_OP_GE  = 3'b101,
        CMP_OP_LTU = 3'b110,
        CMP_OP_GEU = 3'b111
    } cmp_op_e;

    typedef struct packed {
        logic [`DEC_REG_IDX_W-1:0] rd;
        logic [`DEC_REG_IDX_W-1:0] rs1;
        logic [`DEC_REG_IDX_W-1:0] rs2;
        logic [`DEC_FUNCT3_W-1:0]  funct3;
        logic [`DEC_FUNCT7_W-1:0]  funct7;
        instr_format_e             format;
        logic [`DEC_XLEN-1:0]      imm;
    } instr_fields_s;

    typedef struct packed {
        logic         illegal;
        rd_src_e      rd_src;
        logic         rd_we;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        mem_op_e      mem_op;
        logic         mem_signed;
        mem_size_e    mem_size;
        branch_e      branch;
        cmp_op_e      cmp_op;
    } decode_ctrl_s;

    typedef struct packed {
        logic [`DEC_XLEN-1:0] pc;
        logic [`DEC_XLEN-1:0] instr;
    } fetch_to_decode_s;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]      pc;
        logic [`DEC_REG_IDX_W-1:0] rd_idx;
        logic [`DEC_REG_IDX_W-1:0] rs1_idx;
        logic [`DEC_REG_IDX_W-1:0] rs2_idx;
        logic [`DEC_XLEN-1:0]      rs1_val;
        logic [`DEC_XLEN-1:0]      rs2_val;
        logic [`DEC_XLEN-1:0]      immediate;
        decode_ctrl_s              ctrl;
    } decode_to_execute_s;

endpackage

// ==== verilog/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Data path width for PC, instruction and register values
`define DEC_XLEN 32

// Architectural register index, x0 to x31
`define DEC_REG_IDX_W 5

// Major opcode lives in instr[6:2]
`define DEC_OPCODE_W 5

// Function fields of the base encoding
`define DEC_FUNCT3_W 3
`define DEC_FUNCT7_W 7

// Immediate shown for formats that carry none, easy to spot in waves
`define DEC_IMM_BAD 32'hDEADBEEF

`endif
